// File: src/merge_cfg.svh
`ifndef MERGE_CFG_SVH
`define MERGE_CFG_SVH

// one sort key.
`define MERGE_KEY_W 32

// keys per tuple, a power of two so the merge network halves cleanly.
`define MERGE_TUPLE_N 4

`define MERGE_IN_DEPTH 4  // input FIFOs, per side.
`define MERGE_OUT_DEPTH 8  // output FIFO.

`endif

// File: src/merge_types_pkg.sv
`include "merge_cfg.svh"

package merge_types_pkg;

   // zero is never a real key, so an all-zero tuple can mark the end of a run.
   typedef logic [`MERGE_KEY_W-1:0] key_t;

   // key 0 sits in the low bits and is the smallest key of the tuple.
   typedef logic [`MERGE_TUPLE_N*`MERGE_KEY_W-1:0] tuple_t;

endpackage

// File: src/merge_ctrl_pkg.sv
package merge_ctrl_pkg;

   typedef enum logic [1:0] {
      S_LOAD,   // waiting for the first tuple of a run pair.
      S_MERGE,  // top tuple is held, merging.
      S_END     // top flushed, terminator still to go.
   } ctrl_state_e;

   // source of the tuple captured by the output stage.
   typedef enum logic [1:0] {
      EMIT_LOW,
      EMIT_TOP,
      EMIT_TERM
   } emit_e;

endpackage

// File: src/tuple_fifo.sv
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_fifo
   import merge_types_pkg::*;
#(
   parameter int DEPTH = `MERGE_IN_DEPTH
) (
   input  logic   i_clk,
   input  logic   i_arst_n,
   input  tuple_t i_data,
   input  logic   i_push,
   input  logic   i_pop,
   output tuple_t o_data,
   output logic   o_empty,
   output logic   o_full,
   output logic   o_almost_full
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   tuple_t           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign o_data        = mem[rd_ptr];  // head shows without a read delay.
   assign o_empty       = (count == '0);
   assign o_full        = (count == CNT_W'(DEPTH));
   assign o_almost_full = (count >= CNT_W'(DEPTH - 1));  // one free entry or less.

   a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_push |-> !o_full);

   a_no_underflow : assert property (@(posedge i_clk) disable iff (!i_arst_n)
      i_pop |-> !o_empty);

endmodule

// File: src/bitonic_merge_net.sv
`timescale 1ns/1ps
`include "merge_cfg.svh"

module bitonic_merge_net
   import merge_types_pkg::*;
(
   input  tuple_t i_a,
   input  tuple_t i_b,
   output tuple_t o_low,
   output tuple_t o_high
);

   localparam int N      = `MERGE_TUPLE_N;
   localparam int W      = `MERGE_KEY_W;
   localparam int N2     = 2 * N;
   localparam int LEVELS = $clog2(N2);

   // stage[0] is the bitonic input, stage[LEVELS] the sorted result.
   key_t stage [LEVELS+1][N2];

   // a ascending followed by b reversed rises and then falls.
   for (genvar i = 0; i < N; i++) begin : g_in
      assign stage[0][i]         = i_a[i*W +: W];
      assign stage[0][N2-1-i]    = i_b[i*W +: W];
   end

   for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
      localparam int D = N2 >> (lvl + 1);  // compare distance of this half-cleaner.

      for (genvar i = 0; i < N2; i++) begin : g_cell
         if ((i / D) % 2 == 0) begin : g_cmp
            logic swap;

            assign swap               = stage[lvl][i] > stage[lvl][i+D];
            assign stage[lvl+1][i]    = swap ? stage[lvl][i+D] : stage[lvl][i];
            assign stage[lvl+1][i+D]  = swap ? stage[lvl][i] : stage[lvl][i+D];
         end
      end
   end

   for (genvar i = 0; i < N; i++) begin : g_out
      assign o_low[i*W +: W]  = stage[LEVELS][i];
      assign o_high[i*W +: W] = stage[LEVELS][N+i];
   end

endmodule

// File: src/merge_control.sv
`timescale 1ns/1ps

module merge_control
   import merge_types_pkg::*;
   import merge_ctrl_pkg::*;
(
   input  logic  i_clk,
   input  logic  i_arst_n,
   input  key_t  i_a_min,
   input  key_t  i_b_min,
   input  logic  i_a_empty,
   input  logic  i_b_empty,
   input  logic  i_out_afull,
   output logic  o_pop_a,
   output logic  o_pop_b,
   output logic  o_sel_b,
   output logic  o_load_top,
   output logic  o_emit_valid,
   output emit_e o_emit_sel
);

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic        a_term;
   logic        b_term;
   logic        both_term;
   logic        take_a;
   logic        go;

   assign a_term    = (i_a_min == '0);
   assign b_term    = (i_b_min == '0);
   assign both_term = a_term & b_term;

   // a terminator never wins against a real key.
   assign take_a  = b_term | (!a_term && (i_a_min <= i_b_min));
   assign o_sel_b = !take_a;

   // room for the tuple in the output stage and one more.
   assign go = !i_a_empty && !i_b_empty && !i_out_afull;

   always_comb begin
      state_d      = state_q;
      o_pop_a      = 1'b0;
      o_pop_b      = 1'b0;
      o_load_top   = 1'b0;
      o_emit_valid = 1'b0;
      o_emit_sel   = EMIT_LOW;
      if (go) begin
         case (state_q)
            S_LOAD: begin
               if (both_term) begin  // two empty runs.
                  o_emit_valid = 1'b1;
                  o_emit_sel   = EMIT_TERM;
                  o_pop_a      = 1'b1;
                  o_pop_b      = 1'b1;
               end else begin
                  o_pop_a    = take_a;
                  o_pop_b    = !take_a;
                  o_load_top = 1'b1;
                  state_d    = S_MERGE;
               end
            end
            S_MERGE: begin
               if (both_term) begin
                  o_emit_valid = 1'b1;
                  o_emit_sel   = EMIT_TOP;
                  state_d      = S_END;
               end else begin
                  o_pop_a      = take_a;
                  o_pop_b      = !take_a;
                  o_emit_valid = 1'b1;
                  o_emit_sel   = EMIT_LOW;
                  o_load_top   = 1'b1;  // high half stays as the new top.
               end
            end
            S_END: begin
               o_emit_valid = 1'b1;
               o_emit_sel   = EMIT_TERM;
               o_pop_a      = 1'b1;
               o_pop_b      = 1'b1;
               state_d      = S_LOAD;
            end
            default: state_d = S_LOAD;
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= S_LOAD;
      end else begin
         state_q <= state_d;
      end
   end

   a_pop_present : assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (o_pop_a |-> !i_a_empty) and (o_pop_b |-> !i_b_empty));

endmodule

// File: src/tuple_merger.sv
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_merger
   import merge_types_pkg::*;
   import merge_ctrl_pkg::*;
(
   input  logic   i_clk,
   input  logic   i_arst_n,
   input  tuple_t i_a_data,
   input  logic   i_a_empty,
   output logic   o_a_read,
   input  tuple_t i_b_data,
   input  logic   i_b_empty,
   output logic   o_b_read,
   output tuple_t o_out_data,
   output logic   o_out_valid,
   input  logic   i_out_ready
);

   tuple_t a_head;
   tuple_t b_head;
   tuple_t head_mux;
   tuple_t top_q;
   tuple_t net_low;
   tuple_t net_high;
   tuple_t stage_data;
   key_t   a_min;
   key_t   b_min;
   logic   a_empty;
   logic   b_empty;
   logic   a_full;
   logic   b_full;
   logic   out_empty;
   logic   out_afull;
   logic   out_pop;
   logic   pop_a;
   logic   pop_b;
   logic   sel_b;
   logic   load_top;
   logic   emit_valid;
   emit_e  emit_sel;
   logic   stage_valid;

   // upstream is FWFT, so the word is taken in the same cycle as the read.
   assign o_a_read = !i_a_empty && !a_full;
   assign o_b_read = !i_b_empty && !b_full;

   tuple_fifo #(.DEPTH(`MERGE_IN_DEPTH)) fifo_a (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_data        (i_a_data),
      .i_push        (o_a_read),
      .i_pop         (pop_a),
      .o_data        (a_head),
      .o_empty       (a_empty),
      .o_full        (a_full),
      .o_almost_full ()
   );

   tuple_fifo #(.DEPTH(`MERGE_IN_DEPTH)) fifo_b (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_data        (i_b_data),
      .i_push        (o_b_read),
      .i_pop         (pop_b),
      .o_data        (b_head),
      .o_empty       (b_empty),
      .o_full        (b_full),
      .o_almost_full ()
   );

   assign a_min = a_head[`MERGE_KEY_W-1:0];
   assign b_min = b_head[`MERGE_KEY_W-1:0];

   merge_control ctrl_i (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_a_min      (a_min),
      .i_b_min      (b_min),
      .i_a_empty    (a_empty),
      .i_b_empty    (b_empty),
      .i_out_afull  (out_afull),
      .o_pop_a      (pop_a),
      .o_pop_b      (pop_b),
      .o_sel_b      (sel_b),
      .o_load_top   (load_top),
      .o_emit_valid (emit_valid),
      .o_emit_sel   (emit_sel)
   );

   assign head_mux = sel_b ? b_head : a_head;

   bitonic_merge_net net_i (
      .i_a    (top_q),
      .i_b    (head_mux),
      .o_low  (net_low),
      .o_high (net_high)
   );

   // a merge step keeps the high half; the first tuple of a run is taken as is.
   always_ff @(posedge i_clk) begin
      if (load_top) begin
         top_q <= (emit_valid && emit_sel == EMIT_LOW) ? net_high : head_mux;
      end
   end

   always_ff @(posedge i_clk) begin
      if (emit_valid) begin
         case (emit_sel)
            EMIT_LOW: stage_data <= net_low;
            EMIT_TOP: stage_data <= top_q;
            default:  stage_data <= '0;  // terminator.
         endcase
      end
   end

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= emit_valid;
      end
   end

   tuple_fifo #(.DEPTH(`MERGE_OUT_DEPTH)) fifo_out (
      .i_clk         (i_clk),
      .i_arst_n      (i_arst_n),
      .i_data        (stage_data),
      .i_push        (stage_valid),
      .i_pop         (out_pop),
      .o_data        (o_out_data),
      .o_empty       (out_empty),
      .o_full        (),
      .o_almost_full (out_afull)
   );

   assign o_out_valid = !out_empty;
   assign out_pop     = o_out_valid && i_out_ready;

   // a stalled head must not change under the sink.
   a_out_hold : assert property (@(posedge i_clk) disable iff (!i_arst_n)
      (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data)));

endmodule

// File: sim/tuple_merger_tb.sv
`timescale 1ns/1ps
`include "merge_cfg.svh"

module tuple_merger_tb
   import merge_types_pkg::*;
;

   localparam int N    = `MERGE_TUPLE_N;
   localparam int W    = `MERGE_KEY_W;
   localparam int RUNS = 20;

   logic   i_clk;
   logic   i_arst_n;
   tuple_t i_a_data;
   logic   i_a_empty;
   logic   o_a_read;
   tuple_t i_b_data;
   logic   i_b_empty;
   logic   o_b_read;
   tuple_t o_out_data;
   logic   o_out_valid;
   logic   i_out_ready;

   tuple_t      a_q[$];
   tuple_t      b_q[$];
   tuple_t      exp_q[$];
   key_t        ka[$];
   key_t        kb[$];
   tuple_t      exp_t;
   tuple_t      held;
   logic [31:0] lfsr = 32'd74507;
   logic        a_took;
   logic        b_took;
   logic        stalled;
   int          runs_seen;
   int          cycles;
   int          limit;

   tuple_merger dut_i (.*);

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   // taps 32, 22, 2 and 1.
   function automatic logic next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic int unsigned rand_bits(int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = (v << 1) | next_bit();
      end
      return v;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   task automatic compare(input tuple_t got, input tuple_t exp, input string what);
      if (got !== exp) begin
         stop_with_failure($sformatf("ERROR at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
      end
   endtask

   // n tuples of rising keys, then the terminator.
   task automatic push_run(input bit to_b, input int n);
      key_t   k;
      tuple_t t;
      k = '0;
      t = '0;
      for (int i = 0; i < n * N; i++) begin
         k = k + key_t'(rand_bits(8) + 1);
         t[(i % N)*W +: W] = k;
         if (to_b) kb.push_back(k);
         else ka.push_back(k);
         if (i % N == N - 1) begin
            if (to_b) b_q.push_back(t);
            else a_q.push_back(t);
         end
      end
      if (to_b) b_q.push_back('0);
      else a_q.push_back('0);
   endtask

   // the expected run is the merged key list of both sides cut into tuples.
   task automatic merge_model();
      key_t   k;
      tuple_t t;
      int     i;
      i = 0;
      t = '0;
      while (ka.size() > 0 || kb.size() > 0) begin
         if (kb.size() == 0 || (ka.size() > 0 && ka[0] <= kb[0])) k = ka.pop_front();
         else k = kb.pop_front();
         t[(i % N)*W +: W] = k;
         if (i % N == N - 1) exp_q.push_back(t);
         i++;
      end
      exp_q.push_back('0);
   endtask

   initial begin
      i_arst_n    = 1'b0;
      i_a_data    = '0;
      i_a_empty   = 1'b1;
      i_b_data    = '0;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b0;
      a_took      = 1'b0;
      b_took      = 1'b0;
      stalled     = 1'b0;
      held        = '0;
      runs_seen   = 0;
      cycles      = 0;
      // pair 0 is empty on both sides, pairs 1 and 2 on one side.
      for (int r = 0; r < RUNS; r++) begin
         push_run(1'b0, (r == 0 || r == 1) ? 0 : int'(rand_bits(3) % 6));
         push_run(1'b1, (r == 0 || r == 2) ? 0 : int'(rand_bits(3) % 6));
         merge_model();
      end
      limit = 40 * exp_q.size() + 500;
      repeat (10) @(negedge i_clk);
      i_arst_n = 1'b1;
      repeat (5) begin  // idle inputs, so nothing may move.
         @(negedge i_clk);
         compare(o_a_read, 1'b0, "o_a_read while idle");
         compare(o_b_read, 1'b0, "o_b_read while idle");
         compare(o_out_valid, 1'b0, "o_out_valid while idle");
      end
      while (exp_q.size() > 0) begin
         @(negedge i_clk);
         cycles++;
         if (cycles > limit) begin
            stop_with_failure($sformatf("timeout: only %0d of %0d runs came out in %0d cycles",
                                        runs_seen, RUNS, limit));
         end
         if (a_took) void'(a_q.pop_front());
         if (b_took) void'(b_q.pop_front());
         i_a_empty   = (a_q.size() == 0) || (rand_bits(2) == 0);
         i_a_data    = (a_q.size() > 0) ? a_q[0] : '0;
         i_b_empty   = (b_q.size() == 0) || (rand_bits(2) == 0);
         i_b_data    = (b_q.size() > 0) ? b_q[0] : '0;
         i_out_ready = (rand_bits(2) != 0);
         #1;  // read and handshake outputs settle well before the rising edge.
         a_took = o_a_read;
         b_took = o_b_read;
         if (stalled) begin
            compare(o_out_valid, 1'b1, "o_out_valid under back-pressure");
            compare(o_out_data, held, "o_out_data under back-pressure");
         end
         stalled = o_out_valid && !i_out_ready;
         held    = o_out_data;
         if (o_out_valid && i_out_ready) begin
            exp_t = exp_q.pop_front();
            compare(o_out_data, exp_t, $sformatf("run %0d output tuple", runs_seen));
            if (o_out_data == '0) runs_seen++;
         end
      end
      compare(tuple_t'(runs_seen), tuple_t'(RUNS), "number of runs");
      @(negedge i_clk);
      i_a_empty   = 1'b1;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b1;
      repeat (20) begin  // nothing may follow the last terminator.
         @(negedge i_clk);
         compare(o_out_valid, 1'b0, "o_out_valid after the last run");
      end
      $display(">>> PASS");
      $finish;
   end

endmodule

// File: tb.f
+incdir+src
src/merge_types_pkg.sv
src/merge_ctrl_pkg.sv
src/tuple_fifo.sv
src/bitonic_merge_net.sv
src/merge_control.sv
src/tuple_merger.sv
sim/tuple_merger_tb.sv

// File: Bender.yml
package:
  name: tuple_merger

sources:
  - include_dirs:
      - src
    files:
      - src/merge_types_pkg.sv
      - src/merge_ctrl_pkg.sv
      - src/tuple_fifo.sv
      - src/bitonic_merge_net.sv
      - src/merge_control.sv
      - src/tuple_merger.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tuple_merger_tb.sv
